//--- design/mmu_pkg.sv
////////////////////
// Shared sizes and types for the two-port TLB based MMU.
// Imported by every design file that needs an entry, a key or an enum.
////////////////////

package mmu_pkg;

    // array geometry
    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;

    // field widths of one entry
    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;
    localparam int PFN_W  = 20;

    // one TLB entry, an even and an odd page behind a shared tag
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        logic [PFN_W-1:0]  pfn0;
        logic [2:0]        c0;
        logic              d0;
        logic              v0;
        logic [PFN_W-1:0]  pfn1;
        logic [2:0]        c1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    // associative search key
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
    } tlb_key_t;

    typedef enum logic [2:0] {
        TLB_NOP        = 3'd0,
        TLB_READ       = 3'd1,
        TLB_WRITE_IDX  = 3'd2,
        TLB_WRITE_RAND = 3'd3,
        TLB_PROBE      = 3'd4
    } tlb_op_e;

    typedef enum logic [1:0] {
        EXC_NONE    = 2'd0,
        EXC_REFILL  = 2'd1,
        EXC_INVALID = 2'd2,
        EXC_MODIFY  = 2'd3
    } mmu_exc_e;

endpackage

//--- design/tlb_array.sv
////////////////////
// Fully associative TLB storage with one write port, one indexed
// read port and two combinational search ports.
////////////////////

`timescale 1ns/1ns

module tlb_array (
    input  logic                           clk,
    input  logic                           reset,
    // write port
    input  logic                           we,
    input  logic [mmu_pkg::TLB_IDX_W-1:0]  w_index,
    input  mmu_pkg::tlb_entry_t            w_entry,
    // indexed read port
    input  logic [mmu_pkg::TLB_IDX_W-1:0]  r_index,
    output mmu_pkg::tlb_entry_t            r_entry,
    // search port 0, fetch side
    input  mmu_pkg::tlb_key_t              s0_key,
    output logic                           s0_found,
    output logic [mmu_pkg::TLB_IDX_W-1:0]  s0_index,
    output mmu_pkg::tlb_entry_t            s0_entry,
    // search port 1, data side and probe
    input  mmu_pkg::tlb_key_t              s1_key,
    output logic                           s1_found,
    output logic [mmu_pkg::TLB_IDX_W-1:0]  s1_index,
    output mmu_pkg::tlb_entry_t            s1_entry
);

    import mmu_pkg::*;

    tlb_entry_t entries [TLB_NUM];

    logic [TLB_NUM-1:0] match0;
    logic [TLB_NUM-1:0] match1;

    // tag compare against every entry
    // a global entry ignores the asid
    function automatic logic [TLB_NUM-1:0] match_vec(tlb_key_t key);
        logic [TLB_NUM-1:0] m;
        m = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            m[i] = (entries[i].vpn2 == key.vpn2) &&
                   ((entries[i].asid == key.asid) || entries[i].g);
        end
        return m;
    endfunction

    // lowest set bit wins, 0 when nothing is set
    function automatic logic [TLB_IDX_W-1:0] low_index(logic [TLB_NUM-1:0] m);
        logic [TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = TLB_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // storage, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                entries[i] <= '0;
            end
        end else if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    // indexed read for TLBR
    assign r_entry = entries[r_index];

    // search port 0
    always_comb begin
        match0   = match_vec(s0_key);
        s0_found = |match0;
        s0_index = low_index(match0);
        s0_entry = entries[s0_index];
    end

    // search port 1
    always_comb begin
        match1   = match_vec(s1_key);
        s1_found = |match1;
        s1_index = low_index(match1);
        s1_entry = entries[s1_index];
    end

endmodule

//--- design/tlb_op_ctrl.sv
////////////////////
// TLB operation control. Decodes the op strobe into writes, keeps
// the random index, borrows search port 1 for probes and registers
// read and probe results.
////////////////////

`timescale 1ns/1ns

module tlb_op_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           op_valid,
    input  mmu_pkg::tlb_op_e               op,
    input  logic [mmu_pkg::TLB_IDX_W-1:0]  op_index,
    input  mmu_pkg::tlb_entry_t            op_entry,
    input  logic [mmu_pkg::ASID_W-1:0]     asid,
    input  logic [31:0]                    d_vaddr,
    input  logic                           s1_found,
    input  logic [mmu_pkg::TLB_IDX_W-1:0]  s1_index,
    input  mmu_pkg::tlb_entry_t            r_entry,
    output logic                           we,
    output logic [mmu_pkg::TLB_IDX_W-1:0]  w_index,
    output mmu_pkg::tlb_entry_t            w_entry,
    output logic [mmu_pkg::TLB_IDX_W-1:0]  r_index,
    output mmu_pkg::tlb_key_t              s1_key,
    output logic                           op_done,
    output mmu_pkg::tlb_entry_t            read_entry,
    output logic [mmu_pkg::TLB_IDX_W-1:0]  probe_index,
    output logic                           probe_miss
);

    import mmu_pkg::*;

    logic [TLB_IDX_W-1:0] rand_idx;
    logic                 is_probe;

    assign is_probe = op_valid && (op == TLB_PROBE);

    // write decode
    assign we      = op_valid && ((op == TLB_WRITE_IDX) || (op == TLB_WRITE_RAND));
    assign w_index = (op == TLB_WRITE_RAND) ? rand_idx : op_index;
    assign w_entry = op_entry;
    assign r_index = op_index;

    // probe key takes over the data search port for one cycle
    always_comb begin
        if (is_probe) begin
            s1_key.vpn2 = op_entry.vpn2;
            s1_key.asid = op_entry.asid;
        end else begin
            s1_key.vpn2 = d_vaddr[31:13];
            s1_key.asid = asid;
        end
    end

    // free running down counter for TLBWR
    always_ff @(posedge clk) begin
        if (reset || rand_idx == '0) begin
            rand_idx <= TLB_IDX_W'(TLB_NUM - 1);
        end else begin
            rand_idx <= rand_idx - 1'b1;
        end
    end

    // results show up one cycle after the strobe and hold
    always_ff @(posedge clk) begin
        if (reset) begin
            op_done     <= 1'b0;
            read_entry  <= '0;
            probe_index <= '0;
            probe_miss  <= 1'b1;
        end else begin
            op_done <= op_valid;
            if (op_valid && op == TLB_READ) begin
                read_entry <= r_entry;
            end
            if (is_probe) begin
                probe_index <= s1_index;
                probe_miss  <= ~s1_found;
            end
        end
    end

endmodule

//--- design/addr_translate.sv
////////////////////
// Turns one TLB search result and a virtual address into a physical
// address and an exception code. Used once per port.
////////////////////

`timescale 1ns/1ns

module addr_translate (
    input  logic [31:0]          vaddr,
    input  logic                 store,
    input  logic                 found,
    input  mmu_pkg::tlb_entry_t  entry,
    output logic [31:0]          paddr,
    output mmu_pkg::mmu_exc_e    exc
);

    import mmu_pkg::*;

    logic [PFN_W-1:0] pfn;
    logic             v;
    logic             d;

    // bit 12 picks the odd page
    always_comb begin
        if (vaddr[12]) begin
            pfn = entry.pfn1;
            v   = entry.v1;
            d   = entry.d1;
        end else begin
            pfn = entry.pfn0;
            v   = entry.v0;
            d   = entry.d0;
        end
    end

    // exception priority: refill, invalid, then modify
    always_comb begin
        if (!found) begin
            exc = EXC_REFILL;
        end else if (!v) begin
            exc = EXC_INVALID;
        end else if (store && !d) begin
            exc = EXC_MODIFY;
        end else begin
            exc = EXC_NONE;
        end
    end

    // no address leaks out on a fault
    always_comb begin
        if (exc == EXC_NONE) begin
            paddr = {pfn, vaddr[11:0]};
        end else begin
            paddr = '0;
        end
    end

endmodule

//--- design/mmu_top.sv
////////////////////
// MMU top level. One TLB shared by a fetch port and a data port,
// plus the TLBR, TLBWI, TLBWR and TLBP operation interface.
////////////////////

`timescale 1ns/1ns

module mmu_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [mmu_pkg::ASID_W-1:0]     asid,
    // fetch side
    input  logic [31:0]                    i_vaddr,
    output logic [31:0]                    i_paddr,
    output mmu_pkg::mmu_exc_e              i_exc,
    // data side
    input  logic [31:0]                    d_vaddr,
    input  logic                           d_store,
    output logic [31:0]                    d_paddr,
    output mmu_pkg::mmu_exc_e              d_exc,
    // TLB operations
    input  logic                           op_valid,
    input  mmu_pkg::tlb_op_e               op,
    input  logic [mmu_pkg::TLB_IDX_W-1:0]  op_index,
    input  mmu_pkg::tlb_entry_t            op_entry,
    output logic                           op_done,
    output mmu_pkg::tlb_entry_t            read_entry,
    output logic [mmu_pkg::TLB_IDX_W-1:0]  probe_index,
    output logic                           probe_miss
);

    import mmu_pkg::*;

    logic                 we;
    logic [TLB_IDX_W-1:0] w_index;
    tlb_entry_t           w_entry;
    logic [TLB_IDX_W-1:0] r_index;
    tlb_entry_t           r_entry;
    tlb_key_t             s0_key;
    tlb_key_t             s1_key;
    logic                 s0_found;
    logic                 s1_found;
    logic [TLB_IDX_W-1:0] s1_index;
    tlb_entry_t           s0_entry;
    tlb_entry_t           s1_entry;

    // fetch key straight from the address
    assign s0_key.vpn2 = i_vaddr[31:13];
    assign s0_key.asid = asid;

    tlb_array u_array (
        .clk      (clk),
        .reset    (reset),
        .we       (we),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .r_index  (r_index),
        .r_entry  (r_entry),
        .s0_key   (s0_key),
        .s0_found (s0_found),
        .s0_index (),
        .s0_entry (s0_entry),
        .s1_key   (s1_key),
        .s1_found (s1_found),
        .s1_index (s1_index),
        .s1_entry (s1_entry)
    );

    tlb_op_ctrl u_op_ctrl (
        .clk         (clk),
        .reset       (reset),
        .op_valid    (op_valid),
        .op          (op),
        .op_index    (op_index),
        .op_entry    (op_entry),
        .asid        (asid),
        .d_vaddr     (d_vaddr),
        .s1_found    (s1_found),
        .s1_index    (s1_index),
        .r_entry     (r_entry),
        .we          (we),
        .w_index     (w_index),
        .w_entry     (w_entry),
        .r_index     (r_index),
        .s1_key      (s1_key),
        .op_done     (op_done),
        .read_entry  (read_entry),
        .probe_index (probe_index),
        .probe_miss  (probe_miss)
    );

    // fetch never stores
    addr_translate u_i_xlate (
        .vaddr (i_vaddr),
        .store (1'b0),
        .found (s0_found),
        .entry (s0_entry),
        .paddr (i_paddr),
        .exc   (i_exc)
    );

    addr_translate u_d_xlate (
        .vaddr (d_vaddr),
        .store (d_store),
        .found (s1_found),
        .entry (s1_entry),
        .paddr (d_paddr),
        .exc   (d_exc)
    );

endmodule

//--- bench/tb_mmu.sv
////////////////////
// Directed testbench for the MMU top level. Keeps a model of the TLB,
// predicts translations and operation results and counts mismatches.
////////////////////

`timescale 1ns/1ns

module tb_mmu;

    import mmu_pkg::*;

    localparam int OP_TIMEOUT = 20;

    logic                 clk;
    logic                 reset;
    logic [ASID_W-1:0]    asid;
    logic [31:0]          i_vaddr;
    logic [31:0]          i_paddr;
    mmu_exc_e             i_exc;
    logic [31:0]          d_vaddr;
    logic                 d_store;
    logic [31:0]          d_paddr;
    mmu_exc_e             d_exc;
    logic                 op_valid;
    tlb_op_e              op;
    logic [TLB_IDX_W-1:0] op_index;
    tlb_entry_t           op_entry;
    logic                 op_done;
    tlb_entry_t           read_entry;
    logic [TLB_IDX_W-1:0] probe_index;
    logic                 probe_miss;

    // what the TLB should hold
    tlb_entry_t model [TLB_NUM];
    integer     seed;
    int         errors;

    mmu_top u_mmu_top (
        .clk         (clk),
        .reset       (reset),
        .asid        (asid),
        .i_vaddr     (i_vaddr),
        .i_paddr     (i_paddr),
        .i_exc       (i_exc),
        .d_vaddr     (d_vaddr),
        .d_store     (d_store),
        .d_paddr     (d_paddr),
        .d_exc       (d_exc),
        .op_valid    (op_valid),
        .op          (op),
        .op_index    (op_index),
        .op_entry    (op_entry),
        .op_done     (op_done),
        .read_entry  (read_entry),
        .probe_index (probe_index),
        .probe_miss  (probe_miss)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic tlb_entry_t random_entry();
        logic [95:0] r;
        r = {$random(seed), $random(seed), $random(seed)};
        return r[77:0];
    endfunction

    // lowest model slot whose tag matches, -1 on a miss
    function automatic int lowest_match(logic [VPN2_W-1:0] vpn2, logic [ASID_W-1:0] a);
        int hit;
        hit = -1;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (model[i].vpn2 == vpn2 && (model[i].asid == a || model[i].g)) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    function automatic void expect_xlate(input logic [31:0] va, input logic [ASID_W-1:0] a,
                                         input logic st, output logic [31:0] pa,
                                         output mmu_exc_e ex);
        int         hit;
        tlb_entry_t e;
        logic       v;
        logic       d;
        logic [PFN_W-1:0] pfn;
        hit = lowest_match(va[31:13], a);
        e = (hit >= 0) ? model[hit] : '0;
        v = va[12] ? e.v1 : e.v0;
        d = va[12] ? e.d1 : e.d0;
        pfn = va[12] ? e.pfn1 : e.pfn0;
        if (hit < 0) ex = EXC_REFILL;
        else if (!v) ex = EXC_INVALID;
        else if (st && !d) ex = EXC_MODIFY;
        else ex = EXC_NONE;
        pa = (ex == EXC_NONE) ? {pfn, va[11:0]} : 32'h0;
    endfunction

    task automatic mismatch(input string test, input string what,
                            input logic [77:0] exp, input logic [77:0] act);
        $display("MISMATCH %s %s: expected %h actual %h", test, what, exp, act);
        errors++;
    endtask

    // one strobe, then wait for op_done
    task automatic run_op(input tlb_op_e o, input logic [TLB_IDX_W-1:0] idx,
                          input tlb_entry_t e, output int waited);
        @(negedge clk);
        if (op_done !== 1'b0) begin
            $display("ERROR: op_done was still high before the %s strobe", o.name());
            errors++;
        end
        op_valid = 1'b1;
        op       = o;
        op_index = idx;
        op_entry = e;
        @(negedge clk);
        op_valid = 1'b0;
        op       = TLB_NOP;
        waited   = 0;
        while (!op_done && waited < OP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!op_done) begin
            $display("ERROR: op_done never rose after %s", o.name());
            errors++;
        end
    endtask

    task automatic write_entry(input logic [TLB_IDX_W-1:0] idx, input tlb_entry_t e);
        int w;
        run_op(TLB_WRITE_IDX, idx, e, w);
        model[idx] = e;
    endtask

    // both ports at once, outputs sampled at the next rising edge
    task automatic check_xlate(input string test, input logic [31:0] iv,
                               input logic [31:0] dv, input logic st);
        logic [31:0] pa;
        mmu_exc_e    ex;
        @(negedge clk);
        i_vaddr = iv;
        d_vaddr = dv;
        d_store = st;
        @(posedge clk);
        expect_xlate(iv, asid, 1'b0, pa, ex);
        if (i_exc !== ex) mismatch(test, "i_exc", ex, i_exc);
        if (i_paddr !== pa) mismatch(test, "i_paddr", pa, i_paddr);
        expect_xlate(dv, asid, st, pa, ex);
        if (d_exc !== ex) mismatch(test, "d_exc", ex, d_exc);
        if (d_paddr !== pa) mismatch(test, "d_paddr", pa, d_paddr);
    endtask

    task automatic check_probe(input string test, input logic [VPN2_W-1:0] vpn2,
                               input logic [ASID_W-1:0] a);
        tlb_entry_t e;
        int         w;
        int         exp_idx;
        e = '0;
        e.vpn2 = vpn2;
        e.asid = a;
        exp_idx = lowest_match(vpn2, a);
        run_op(TLB_PROBE, '0, e, w);
        if (probe_miss !== (exp_idx < 0)) mismatch(test, "probe_miss", exp_idx < 0, probe_miss);
        if (exp_idx >= 0 && probe_index !== exp_idx[3:0]) begin
            mismatch(test, "probe_index", exp_idx[3:0], probe_index);
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] r;
        for (int n = 0; n < 4; n++) begin
            r = $random(seed);
            // bit 31 set keeps the key away from the cleared entries
            check_probe("reset_state", {1'b1, r[17:0]}, r[25:18]);
            check_xlate("reset_state", {1'b1, r[30:0]}, {1'b1, r[31:1]}, r[0]);
        end
    endtask

    task automatic test_write_read();
        int w;
        for (int i = 0; i < TLB_NUM; i++) begin
            write_entry(i[3:0], random_entry());
        end
        for (int i = 0; i < TLB_NUM; i++) begin
            run_op(TLB_READ, i[3:0], '0, w);
            if (w != 0) begin
                $display("ERROR: read of slot %0d finished %0d cycles late", i, w);
                errors++;
            end
            if (read_entry !== model[i]) mismatch("write_read", "read_entry", model[i], read_entry);
        end
    endtask

    task automatic test_translate();
        tlb_entry_t e;
        logic [31:0] r;
        logic [31:0] r2;
        r = $random(seed);
        @(negedge clk);
        asid = r[7:0];
        // low vpn2 bits hold the slot number, so every tag differs
        for (int i = 0; i < TLB_NUM; i++) begin
            e = random_entry();
            e.vpn2 = {e.vpn2[18:4], i[3:0]};
            e.asid = asid;
            e.g  = 1'b0;
            e.v0 = 1'b1;
            e.v1 = 1'b1;
            e.d0 = 1'b1;
            e.d1 = 1'b1;
            write_entry(i[3:0], e);
        end
        for (int n = 0; n < 32; n++) begin
            r  = $random(seed);
            r2 = $random(seed);
            check_xlate("translate", {model[r[3:0]].vpn2, r[16:4]},
                        {model[r2[3:0]].vpn2, r2[16:4]}, r2[20]);
        end
    endtask

    task automatic test_asid_global();
        tlb_entry_t e;
        logic [31:0] r;
        e = random_entry();
        e.vpn2 = {15'h0abc, 4'h0};
        e.asid = asid ^ 8'h5a;
        e.g  = 1'b0;
        e.v0 = 1'b1;
        e.v1 = 1'b1;
        e.d0 = 1'b1;
        e.d1 = 1'b1;
        write_entry(4'd0, e);
        check_xlate("asid_global", {e.vpn2, 13'h0123}, {e.vpn2, 13'h1456}, 1'b0);
        e.g = 1'b1;
        write_entry(4'd0, e);
        for (int n = 0; n < 4; n++) begin
            r = $random(seed);
            @(negedge clk);
            asid = r[7:0];
            check_xlate("asid_global", {e.vpn2, r[20:8]}, {e.vpn2, r[31:19]}, r[0]);
        end
    endtask

    task automatic test_exceptions();
        tlb_entry_t e;
        e = random_entry();
        e.vpn2 = {15'h1234, 4'h1};
        e.asid = asid;
        e.g  = 1'b0;
        // even half invalid, odd half valid but clean
        e.v0 = 1'b0;
        e.d0 = 1'b1;
        e.v1 = 1'b1;
        e.d1 = 1'b0;
        write_entry(4'd1, e);
        check_xlate("exceptions", {e.vpn2, 13'h0040}, {e.vpn2, 13'h0ff0}, 1'b0);
        check_xlate("exceptions", {e.vpn2, 13'h1040}, {e.vpn2, 13'h1ff0}, 1'b1);
        check_xlate("exceptions", {e.vpn2, 13'h1800}, {e.vpn2, 13'h1004}, 1'b0);
    endtask

    task automatic test_probe_random_write();
        tlb_entry_t           e;
        int                   w;
        logic [TLB_IDX_W-1:0] slot;
        check_probe("probe_random_write", model[5].vpn2, model[5].asid);
        e = random_entry();
        e.vpn2 = {15'h7ff3, 4'hf};
        e.asid = asid;
        e.g  = 1'b0;
        e.v0 = 1'b1;
        e.v1 = 1'b1;
        e.d0 = 1'b1;
        e.d1 = 1'b1;
        check_probe("probe_random_write", e.vpn2, e.asid);
        run_op(TLB_WRITE_RAND, '0, e, w);
        run_op(TLB_PROBE, '0, e, w);
        if (probe_miss !== 1'b0) begin
            $display("ERROR: probe did not find the entry written at the random index");
            errors++;
        end else begin
            slot = probe_index;
            run_op(TLB_READ, slot, '0, w);
            if (read_entry !== e) mismatch("probe_random_write", "read_entry", e, read_entry);
            model[slot] = e;
            check_xlate("probe_random_write", {e.vpn2, 13'h0abc}, {e.vpn2, 13'h1def}, 1'b1);
        end
    endtask

    initial begin
        seed     = 60779;
        errors   = 0;
        reset    = 1'b1;
        asid     = '0;
        i_vaddr  = '0;
        d_vaddr  = '0;
        d_store  = 1'b0;
        op_valid = 1'b0;
        op       = TLB_NOP;
        op_index = '0;
        op_entry = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_write_read();
        test_translate();
        test_asid_global();
        test_exceptions();
        test_probe_random_write();

        $display("tb_mmu done, %0d errors", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
design/mmu_pkg.sv
design/tlb_array.sv
design/tlb_op_ctrl.sv
design/addr_translate.sv
design/mmu_top.sv
bench/tb_mmu.sv

//--- run_sim.sh
#!/bin/sh
# Builds the MMU testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mmu -f files.f -o tb_mmu_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_mmu_sim > sim.log 2>&1 || { echo "simulation aborted, see sim.log"; exit 1; }

grep -q "RESULT: PASS" sim.log && echo "simulation passed" || {
    echo "simulation failed, see sim.log"
    exit 1
}
